// ==== common/traffic_pkg.sv ====
`default_nettype none

package traffic_pkg;

    // ********************************************************
    // Phase encoding, first four in lamp decode order
    // ********************************************************
    typedef enum logic [2:0] {
        PH_B_GREEN  = 3'd0,     // A red, B green
        PH_B_YELLOW = 3'd1,     // A red, B yellow flashing
        PH_A_GREEN  = 3'd2,     // A green, B red
        PH_A_YELLOW = 3'd3,     // A yellow flashing, B red
        PH_ALL_RED  = 3'd4      // Both roads held at red
    } phase_t;

    // Seconds count, 7 bits covers up to 99 s
    localparam int SEC_W = 7;
    typedef logic [SEC_W-1:0] sec_t;

    // ********************************************************
    // Lamp vector, A lamps in the upper half
    // ********************************************************
    typedef logic [5:0] lamp_t;

    localparam int LAMP_A_RED = 5;
    localparam int LAMP_A_GRN = 4;
    localparam int LAMP_A_YEL = 3;
    localparam int LAMP_B_RED = 2;
    localparam int LAMP_B_GRN = 1;
    localparam int LAMP_B_YEL = 0;

    // Only the two reds lit
    localparam lamp_t LAMP_ALL_RED = 6'b100100;

endpackage

`default_nettype wire

// ==== traffic/phase_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module phase_sequencer
    import traffic_pkg::*;
#(
    parameter int TICK_CYCLES = 50_000_000,    // Clock cycles per second
    parameter int GREEN_SECS  = 30,            // Green phase length
    parameter int YELLOW_SECS = 5              // Yellow phase length
) (
    input  logic   sys_clk,
    input  logic   sys_rst_n,
    input  logic   all_red,        // Hold both roads at red
    output phase_t phase,          // Registered phase to lamp decode
    output sec_t   remain          // Seconds left in saved phase
);

    localparam int TICK_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [TICK_W-1:0] tick_cnt;   // Second divider
    logic              sec_tick;   // One pulse per second
    logic              step;       // Last second of the phase ends
    phase_t            sav_phase;  // Phase kept across an all-red hold
    phase_t            nxt_sav;
    phase_t            adv_phase;  // Phase that follows sav_phase
    sec_t              adv_secs;   // And its duration

    // ********************************************************
    // Second tick divider
    // ********************************************************
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            tick_cnt <= '0;
        else if (all_red)
            tick_cnt <= '0;                              // Second restarts in full
        else if (tick_cnt == TICK_W'(TICK_CYCLES - 1))
            tick_cnt <= '0;                              // Wrap
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    // Divider is parked at zero during hold, so no tick there
    assign sec_tick = !all_red && (tick_cnt == TICK_W'(TICK_CYCLES - 1));
    assign step     = sec_tick && (remain == sec_t'(1));

    // ********************************************************
    // Fixed phase order and the next duration
    // ********************************************************
    always_comb begin
        case (sav_phase)
            PH_B_GREEN: begin
                adv_phase = PH_B_YELLOW;
                adv_secs  = sec_t'(YELLOW_SECS);
            end
            PH_B_YELLOW: begin
                adv_phase = PH_A_GREEN;
                adv_secs  = sec_t'(GREEN_SECS);
            end
            PH_A_GREEN: begin
                adv_phase = PH_A_YELLOW;
                adv_secs  = sec_t'(YELLOW_SECS);
            end
            PH_A_YELLOW: begin
                adv_phase = PH_B_GREEN;
                adv_secs  = sec_t'(GREEN_SECS);
            end
            default: begin                               // Unreachable, recover to start
                adv_phase = PH_B_GREEN;
                adv_secs  = sec_t'(GREEN_SECS);
            end
        endcase
    end

    assign nxt_sav = step ? adv_phase : sav_phase;

    // Saved phase, frozen while all_red since step stays low
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            sav_phase <= PH_B_GREEN;
        else
            sav_phase <= nxt_sav;
    end

    // ********************************************************
    // Seconds countdown
    // ********************************************************
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            remain <= sec_t'(GREEN_SECS);
        else if (step)
            remain <= adv_secs;                          // Load next phase length
        else if (sec_tick)
            remain <= remain - 1'b1;
    end

    // Output phase, same edge as the saved phase update
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            phase <= PH_B_GREEN;
        else if (all_red)
            phase <= PH_ALL_RED;
        else
            phase <= nxt_sav;                            // Resume where it left off
    end

endmodule

`default_nettype wire

// ==== traffic/lamp_driver.sv ====
`timescale 1ns/10ps
`default_nettype none

module lamp_driver
    import traffic_pkg::*;
#(
    parameter int TWINKLE_CYCLES = 10_000_000      // Half period of the flash
) (
    input  logic   sys_clk,
    input  logic   sys_rst_n,
    input  phase_t phase,
    output lamp_t  lamp            // Registered lamp enables
);

    localparam int TW_W = (TWINKLE_CYCLES > 1) ? $clog2(TWINKLE_CYCLES) : 1;

    logic [TW_W-1:0] tw_cnt;       // Free-running flash timer
    logic            tw_wrap;
    lamp_t           nxt_lamp;

    // ********************************************************
    // Twinkle counter
    // ********************************************************
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            tw_cnt <= '0;
        else if (tw_wrap)
            tw_cnt <= '0;
        else
            tw_cnt <= tw_cnt + 1'b1;
    end

    assign tw_wrap = (tw_cnt == TW_W'(TWINKLE_CYCLES - 1));

    // ********************************************************
    // Phase decode
    // ********************************************************
    always_comb begin
        nxt_lamp = '0;                                   // Green decode clears yellows
        case (phase)
            PH_B_GREEN: begin
                nxt_lamp[LAMP_A_RED] = 1'b1;
                nxt_lamp[LAMP_B_GRN] = 1'b1;
            end
            PH_B_YELLOW: begin
                nxt_lamp[LAMP_A_RED] = 1'b1;
                // Toggle on wrap, otherwise hold
                nxt_lamp[LAMP_B_YEL] = tw_wrap ? ~lamp[LAMP_B_YEL] : lamp[LAMP_B_YEL];
            end
            PH_A_GREEN: begin
                nxt_lamp[LAMP_A_GRN] = 1'b1;
                nxt_lamp[LAMP_B_RED] = 1'b1;
            end
            PH_A_YELLOW: begin
                nxt_lamp[LAMP_B_RED] = 1'b1;
                nxt_lamp[LAMP_A_YEL] = tw_wrap ? ~lamp[LAMP_A_YEL] : lamp[LAMP_A_YEL];
            end
            default: nxt_lamp = LAMP_ALL_RED;            // PH_ALL_RED and anything odd
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            lamp <= LAMP_ALL_RED;                        // Safe state out of reset
        else
            lamp <= nxt_lamp;
    end

endmodule

`default_nettype wire

// ==== logic/countdown_bcd.sv ====
`timescale 1ns/10ps
`default_nettype none

module countdown_bcd
    import traffic_pkg::*;
(
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  sec_t       remain,         // Binary seconds, never above 99
    output logic [3:0] digit_tens,
    output logic [3:0] digit_ones
);

    localparam int BCD_W = 8;          // Two digits

    // BCD field on top, binary shifted out of the bottom
    logic [BCD_W+SEC_W-1:0] shf;

    // ********************************************************
    // Shift-and-add-three, one pass per input bit
    // ********************************************************
    always_comb begin
        shf = {{BCD_W{1'b0}}, remain};
        for (int i = 0; i < SEC_W; i++) begin
            // Ones nibble
            if (shf[SEC_W+3:SEC_W] > 4'd4)
                shf[SEC_W+3:SEC_W] = shf[SEC_W+3:SEC_W] + 4'd3;
            // Tens nibble
            if (shf[SEC_W+7:SEC_W+4] > 4'd4)
                shf[SEC_W+7:SEC_W+4] = shf[SEC_W+7:SEC_W+4] + 4'd3;
            shf = shf << 1;
        end
    end

    // Registered digits, one cycle behind remain
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            digit_tens <= 4'd0;
            digit_ones <= 4'd0;
        end else begin
            digit_tens <= shf[SEC_W+7:SEC_W+4];
            digit_ones <= shf[SEC_W+3:SEC_W];
        end
    end

endmodule

`default_nettype wire

// ==== logic/traffic_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module traffic_top
    import traffic_pkg::*;
#(
    parameter int TICK_CYCLES    = 50_000_000,  // 1 s at 50 MHz
    parameter int GREEN_SECS     = 30,
    parameter int YELLOW_SECS    = 5,
    parameter int TWINKLE_CYCLES = 10_000_000   // 0.2 s flash half period
) (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       all_red,     // Emergency hold
    output phase_t     phase,
    output lamp_t      lamp,
    output logic [3:0] digit_tens,
    output logic [3:0] digit_ones
);

    sec_t remain;                   // Seconds left, to the display path

    // ********************************************************
    // Sequencer, lamp decode and display path
    // ********************************************************
    phase_sequencer #(
        .TICK_CYCLES (TICK_CYCLES),
        .GREEN_SECS  (GREEN_SECS),
        .YELLOW_SECS (YELLOW_SECS)
    ) u_phase_sequencer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .all_red   (all_red),
        .phase     (phase),
        .remain    (remain)
    );

    lamp_driver #(
        .TWINKLE_CYCLES (TWINKLE_CYCLES)
    ) u_lamp_driver (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .phase     (phase),
        .lamp      (lamp)
    );

    countdown_bcd u_countdown_bcd (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .remain     (remain),
        .digit_tens (digit_tens),
        .digit_ones (digit_ones)
    );

endmodule

`default_nettype wire

// ==== tests/traffic_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module traffic_checker
    import traffic_pkg::*;
(
    input logic   sys_clk,
    input logic   sys_rst_n,
    input phase_t phase,
    input lamp_t  lamp
);

    // ********************************************************
    // Lamp legality per road and across roads
    // ********************************************************
    // Lamp shows the phase of the previous edge, so dark only in that road's yellow
    a_road_a_one: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $onehot({lamp[LAMP_A_RED], lamp[LAMP_A_GRN], lamp[LAMP_A_YEL]})
            || (!lamp[LAMP_A_RED] && !lamp[LAMP_A_GRN] && $past(phase) == PH_A_YELLOW))
        else $error("Road A does not show exactly one lamp");

    a_road_b_one: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $onehot({lamp[LAMP_B_RED], lamp[LAMP_B_GRN], lamp[LAMP_B_YEL]})
            || (!lamp[LAMP_B_RED] && !lamp[LAMP_B_GRN] && $past(phase) == PH_B_YELLOW))
        else $error("Road B does not show exactly one lamp");

    a_a_red_guard: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (lamp[LAMP_B_GRN] || lamp[LAMP_B_YEL]) |-> lamp[LAMP_A_RED])
        else $error("Road A red dark while road B moves");    // Conflict

    a_b_red_guard: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (lamp[LAMP_A_GRN] || lamp[LAMP_A_YEL]) |-> lamp[LAMP_B_RED])
        else $error("Road B red dark while road A moves");

    // Holds in and out of all-red are not steps
    a_phase_order: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (phase != $past(phase) && phase != PH_ALL_RED && $past(phase) != PH_ALL_RED)
            |-> phase[1:0] == $past(phase[1:0]) + 2'd1)
        else $error("Phase left the fixed order");

endmodule

bind lamp_driver traffic_checker u_traffic_checker (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .phase     (phase),
    .lamp      (lamp)
);

`default_nettype wire

// ==== tests/traffic_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module traffic_tb
    import traffic_pkg::*;
();

    localparam int TICK      = 10;                       // Cycles per second
    localparam int GREEN     = 5;
    localparam int YELLOW    = 3;
    localparam int TWINKLE   = 4;
    localparam int ROUND     = 2 * (GREEN + YELLOW) * TICK;  // All four phases once
    localparam int MAX_HOLD  = 20;
    localparam int N_HOLDS   = 2;
    // Twice four rounds plus the holds
    localparam int LIMIT     = 2 * (4 * ROUND + N_HOLDS * (MAX_HOLD + TICK));

    logic        sys_clk;
    logic        sys_rst_n;
    logic        all_red;
    phase_t      phase;
    lamp_t       lamp;
    logic [3:0]  digit_tens;
    logic [3:0]  digit_ones;
    logic [31:0] lfsr;
    int          cyc_cnt = 0;
    int          smp = 0;                                // One per sample point
    int          err_cnt = 0;

    traffic_top #(
        .TICK_CYCLES    (TICK),
        .GREEN_SECS     (GREEN),
        .YELLOW_SECS    (YELLOW),
        .TWINKLE_CYCLES (TWINKLE)
    ) UUT (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .all_red    (all_red),
        .phase      (phase),
        .lamp       (lamp),
        .digit_tens (digit_tens),
        .digit_ones (digit_ones)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cyc_cnt);
            $display("ERRORS FOUND");
            $fatal(1, "Timeout");
        end
    end

    // ********************************************************
    // Reporting, random bits and the expected-value rules
    // ********************************************************
    task automatic fail_value(input string name, input int exp, input int act);
        err_cnt++;
        $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        $display("ERRORS FOUND");
        $fatal(1, "Value check failed");
    endtask

    task automatic fail_msg(input string msg);
        err_cnt++;
        $display("%s, at %0t", msg, $time);
        $display("ERRORS FOUND");
        $fatal(1, "Check failed");
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic int draw_bits(input int n);
        int   val;
        logic fb;
        val = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = (val << 1) | int'(fb);
        end
        return val;
    endfunction

    function automatic phase_t order_next(input phase_t p);
        case (p)
            PH_B_GREEN:  return PH_B_YELLOW;
            PH_B_YELLOW: return PH_A_GREEN;
            PH_A_GREEN:  return PH_A_YELLOW;
            default:     return PH_B_GREEN;
        endcase
    endfunction

    function automatic int phase_len(input phase_t p);    // In cycles
        return ((p == PH_B_GREEN || p == PH_A_GREEN) ? GREEN : YELLOW) * TICK;
    endfunction

    // Static lamps with the flashing yellow left dark
    function automatic lamp_t lamp_of(input phase_t p);
        case (p)
            PH_B_GREEN:  return lamp_t'((1 << LAMP_A_RED) | (1 << LAMP_B_GRN));
            PH_B_YELLOW: return lamp_t'(1 << LAMP_A_RED);
            PH_A_GREEN:  return lamp_t'((1 << LAMP_A_GRN) | (1 << LAMP_B_RED));
            PH_A_YELLOW: return lamp_t'(1 << LAMP_B_RED);
            default:     return LAMP_ALL_RED;
        endcase
    endfunction

    function automatic lamp_t flash_mask(input phase_t p);
        if (p == PH_B_YELLOW)
            return lamp_t'(1 << LAMP_B_YEL);
        else if (p == PH_A_YELLOW)
            return lamp_t'(1 << LAMP_A_YEL);
        else
            return '0;
    endfunction

    task automatic next_cycle();                         // Sample and drive point
        @(posedge sys_clk);
        #10;
        smp++;
    endtask

    // ********************************************************
    // Directed tests
    // ********************************************************
    task automatic test_reset();
        repeat (3) begin
            next_cycle();
            assert (lamp == LAMP_ALL_RED) else fail_value("lamp", LAMP_ALL_RED, lamp);
            assert ({digit_tens, digit_ones} == 8'h00)
                else fail_value("digits", 0, {digit_tens, digit_ones});
            assert (phase == PH_B_GREEN) else fail_value("phase", PH_B_GREEN, phase);
            assert (UUT.remain == sec_t'(GREEN)) else fail_value("remain", GREEN, UUT.remain);
        end
        sys_rst_n = 1'b1;                                // Released 10 ns after third edge
    endtask

    task automatic test_phase_order();
        phase_t     cur;
        phase_t     lamp_ph;                             // Phase the lamp decodes now
        int         start;
        int         secs;                                // Own count of seconds left
        int         sub;                                 // Cycles into the second
        int         shown;
        int         changes;
        logic [7:0] last_dig;
        cur      = phase;
        lamp_ph  = phase;
        start    = smp;
        secs     = GREEN;
        sub      = 0;
        changes  = 0;
        last_dig = {digit_tens, digit_ones};
        while (changes < 8) begin                        // Two rounds
            shown = secs;                                // Digits trail by one cycle
            sub++;
            if (sub == TICK) begin
                sub  = 0;
                secs = (secs == 1) ? phase_len(order_next(cur)) / TICK : secs - 1;
            end
            next_cycle();
            assert ((lamp & ~flash_mask(lamp_ph)) == lamp_of(lamp_ph))
                else fail_value("lamp", lamp_of(lamp_ph), lamp);
            if ({digit_tens, digit_ones} != last_dig) begin
                assert (digit_tens == shown / 10 && digit_ones == shown % 10)
                    else fail_value("digits", (shown / 10) * 16 + shown % 10,
                                    {digit_tens, digit_ones});
                last_dig = {digit_tens, digit_ones};
            end
            if (phase != cur) begin
                assert (phase == order_next(cur)) else fail_value("phase", order_next(cur), phase);
                assert (smp - start == phase_len(cur))
                    else fail_value("phase length", phase_len(cur), smp - start);
                cur   = phase;
                start = smp;
                changes++;
            end
            lamp_ph = phase;
        end
    endtask

    task automatic test_yellow_flash();
        phase_t lamp_ph;
        lamp_t  fm;
        logic   last_bit;
        int     hold;                                    // Cycles at the same level
        int     toggles;
        int     done;
        lamp_ph  = phase;
        done     = 0;
        hold     = 0;
        toggles  = 0;
        last_bit = 1'b0;                                 // Cleared by the green decode
        while (done < 2) begin
            next_cycle();
            fm = flash_mask(lamp_ph);
            if (fm != '0) begin
                assert ((lamp & ~fm) == lamp_of(lamp_ph))
                    else fail_value("lamp", lamp_of(lamp_ph), lamp);
                if (((lamp & fm) != '0) != last_bit) begin
                    toggles++;
                    hold     = 1;
                    last_bit = ~last_bit;
                end else begin
                    hold++;
                end
                assert (hold <= TWINKLE + 1) else fail_msg("Flashing yellow held too long");
            end else if (hold != 0) begin                // Yellow window just ended
                assert (toggles > 0) else fail_msg("Flashing yellow never toggled");
                done++;
                hold     = 0;
                toggles  = 0;
                last_bit = 1'b0;
            end
            lamp_ph = phase;
        end
    endtask

    task automatic test_all_red();
        phase_t     target;
        phase_t     prev;
        int         hold;
        int         offset;
        int         start;
        int         ext;
        int         secs_left;                           // Own count at the hold
        logic [7:0] frozen;
        target = phase_t'(draw_bits(2));
        hold   = 5 + draw_bits(4);                       // 5 to MAX_HOLD
        prev   = phase;
        while (!(phase == target && prev != target)) begin   // Entry of the target phase
            prev = phase;
            next_cycle();
        end
        start  = smp;
        offset = draw_bits(5) % (phase_len(target) - 1);
        // Whole seconds already gone at the cycle all_red is raised
        secs_left = phase_len(target) / TICK - offset / TICK;
        frozen    = 8'((secs_left / 10) * 16 + secs_left % 10);
        repeat (offset) next_cycle();
        all_red = 1'b1;
        for (int i = 1; i <= hold; i++) begin
            next_cycle();
            assert (phase == PH_ALL_RED) else fail_value("phase", PH_ALL_RED, phase);
            if (i == 1) begin
                assert ((lamp & ~flash_mask(target)) == lamp_of(target))
                    else fail_value("lamp", lamp_of(target), lamp);
            end else begin
                assert (lamp == LAMP_ALL_RED) else fail_value("lamp", LAMP_ALL_RED, lamp);
            end
            assert ({digit_tens, digit_ones} == frozen)
                else fail_value("digits", frozen, {digit_tens, digit_ones});
        end
        all_red = 1'b0;
        next_cycle();
        assert (phase == target) else fail_value("phase", target, phase);
        assert (lamp == LAMP_ALL_RED) else fail_value("lamp", LAMP_ALL_RED, lamp);
        assert ({digit_tens, digit_ones} == frozen)
            else fail_value("digits", frozen, {digit_tens, digit_ones});
        while (phase == target)
            next_cycle();
        assert (phase == order_next(target)) else fail_value("phase", order_next(target), phase);
        ext = smp - start - phase_len(target);           // Stretch from the hold
        assert (ext >= hold && ext <= hold + TICK)
            else fail_msg($sformatf("Phase stretched by %0d cycles after a hold of %0d",
                                    ext, hold));
    endtask

    initial begin
        sys_rst_n = 1'b0;
        all_red   = 1'b0;
        lfsr      = 32'h2e2a;
        test_reset();
        test_phase_order();
        test_yellow_flash();
        repeat (N_HOLDS) test_all_red();
        if (err_cnt == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/traffic_pkg.sv
traffic/phase_sequencer.sv
traffic/lamp_driver.sv
logic/countdown_bcd.sv
logic/traffic_top.sv
tests/traffic_checker.sv
tests/traffic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the traffic light testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module traffic_tb \
    -f filelist.f -o traffic_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
# A nonzero exit from an assertion stop or a fatal also counts as failure
./obj_dir/traffic_sim > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed"
